// ==== RISCV_TOP.f ====
+incdir+include
rtl/riscv_isa_pkg.sv
rtl/riscv_pipe_pkg.sv
rtl/fwd_if.sv
rtl/riscv_decoder.sv
rtl/riscv_alu.sv
rtl/riscv_forward_unit.sv
rtl/RISCV_TOP.sv
tb/RISCV_TOP_tb.sv

// ==== include/riscv_macros.svh ====
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath widths
`define XLEN      32
`define REG_IDX_W 5

// byte address into the 4 KB instruction memory
`define PC_W      12

// EBREAK marks the end of a program
`define HALT_INSTR 32'h0010_0073

`endif

// ==== rtl/RISCV_TOP.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module RISCV_TOP (
	input  logic                    CLK,
	input  logic                    RSTn,
	output logic                    I_MEM_CSN,
	input  riscv_isa_pkg::word_t    I_MEM_DI,
	output riscv_pipe_pkg::pcAddr_t I_MEM_ADDR,
	output logic                    D_MEM_CSN,
	input  riscv_isa_pkg::word_t    D_MEM_DI,
	output riscv_isa_pkg::word_t    D_MEM_DOUT,
	output logic [11:0]             D_MEM_ADDR,
	output logic                    D_MEM_WEN,
	output logic                    RF_WE,
	output riscv_isa_pkg::regIdx_t  RF_RA1,
	output riscv_isa_pkg::regIdx_t  RF_RA2,
	output riscv_isa_pkg::regIdx_t  RF_WA1,
	input  riscv_isa_pkg::word_t    RF_RD1,
	input  riscv_isa_pkg::word_t    RF_RD2,
	output riscv_isa_pkg::word_t    RF_WD,
	output logic                    HALT,
	output riscv_isa_pkg::word_t    NUM_INST
);
	riscv_pipe_pkg::pcAddr_t pc, pcPlus4, exTarget, exBranchTarget, exLink;
	logic                    fetchStop, fetchAdv, stall, flush, idHaltGo, exBrTaken, exZero;

	// decoder outputs in ID
	riscv_isa_pkg::regIdx_t  decRs1, decRs2, decRd;
	riscv_isa_pkg::word_t    decImm, idRd1, idRd2;
	riscv_isa_pkg::aluOp_e   decAluOp;
	riscv_pipe_pkg::branch_e decBranch;
	riscv_pipe_pkg::wbSel_e  decWbSel;
	logic decAluSrcImm, decRegWrite, decMemRead, decMemWrite;
	logic decJump, decJumpReg, decHalt;

	// IF/ID
	logic                    ifIdValid;
	riscv_pipe_pkg::pcAddr_t ifIdPc;
	riscv_isa_pkg::word_t    ifIdInstr;

	// ID/EX
	logic                    idExValid, idExRegWrite, idExMemRead, idExMemWrite;
	logic                    idExJump, idExJumpReg, idExAluSrcImm, idExHalt;
	riscv_pipe_pkg::pcAddr_t idExPc;
	riscv_isa_pkg::regIdx_t  idExRs1, idExRs2, idExRd;
	riscv_isa_pkg::word_t    idExImm, idExRd1, idExRd2;
	riscv_isa_pkg::aluOp_e   idExAluOp;
	riscv_pipe_pkg::branch_e idExBranch;
	riscv_pipe_pkg::wbSel_e  idExWbSel;
	riscv_isa_pkg::word_t    exOpA, exOpB, exAluB, exAluResult, memFwdVal;

	// EX/MEM
	logic                    exMemValid, exMemRegWrite, exMemMemRead, exMemMemWrite, exMemHalt;
	riscv_isa_pkg::word_t    exMemAlu, exMemStoreData;
	riscv_pipe_pkg::pcAddr_t exMemLink;
	riscv_isa_pkg::regIdx_t  exMemRd;
	riscv_pipe_pkg::wbSel_e  exMemWbSel;

	// MEM/WB
	logic                    memWbValid, memWbRegWrite, memWbHalt;
	riscv_isa_pkg::word_t    memWbAlu, memWbLoad;
	riscv_pipe_pkg::pcAddr_t memWbLink;
	riscv_isa_pkg::regIdx_t  memWbRd;
	riscv_pipe_pkg::wbSel_e  memWbWbSel;

	fwd_if fwdBus ();

	riscv_forward_unit uFwdUnit (.fwd(fwdBus.unit));

	function automatic riscv_isa_pkg::word_t pickOperand(
		input riscv_pipe_pkg::fwdSel_e sel,
		input riscv_isa_pkg::word_t    regVal,
		input riscv_isa_pkg::word_t    memVal,
		input riscv_isa_pkg::word_t    wbVal
	);
		case (sel)
			riscv_pipe_pkg::FWD_MEM: return memVal;
			riscv_pipe_pkg::FWD_WB:  return wbVal;
			default:                 return regVal;
		endcase
	endfunction

	assign I_MEM_ADDR = pc;
	assign pcPlus4    = pc + riscv_pipe_pkg::pcAddr_t'(4);
	assign fetchAdv   = !I_MEM_CSN && !stall && !idHaltGo;

	// fetch stops for good once EBREAK moves on from ID
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc        <= '0;
			fetchStop <= 1'b0;
			I_MEM_CSN <= 1'b1;
		end else begin
			if (flush)
				pc <= exTarget;
			else if (fetchAdv && !HALT)
				pc <= pcPlus4;
			fetchStop <= fetchStop || idHaltGo;
			I_MEM_CSN <= fetchStop || idHaltGo;
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn || flush)
			ifIdValid <= 1'b0;
		else if (!stall)
			ifIdValid <= fetchAdv;
	end

	always_ff @(posedge CLK) begin
		if (!stall) begin
			ifIdPc    <= pc;
			ifIdInstr <= I_MEM_DI;
		end
	end

	riscv_decoder uDecoder (
		.instr(ifIdInstr),     .rs1(decRs1),         .rs2(decRs2),
		.rd(decRd),            .imm(decImm),         .aluOp(decAluOp),
		.aluSrcImm(decAluSrcImm), .regWrite(decRegWrite), .memRead(decMemRead),
		.memWrite(decMemWrite), .branch(decBranch),  .jump(decJump),
		.jumpReg(decJumpReg),  .wbSel(decWbSel),     .halt(decHalt)
	);

	assign RF_RA1 = decRs1;
	assign RF_RA2 = decRs2;
	// a write in WB is not yet in the register file this cycle
	assign idRd1  = (RF_WE && RF_WA1 == decRs1) ? RF_WD : RF_RD1;
	assign idRd2  = (RF_WE && RF_WA1 == decRs2) ? RF_WD : RF_RD2;

	assign stall    = fwdBus.stall && ifIdValid;
	assign idHaltGo = ifIdValid && decHalt && !flush && !stall;

	always_ff @(posedge CLK) begin
		if (RSTn || flush || stall || !ifIdValid) begin  // bubble
			idExValid    <= 1'b0;
			idExRegWrite <= 1'b0;
			idExMemRead  <= 1'b0;
			idExMemWrite <= 1'b0;
			idExBranch   <= riscv_pipe_pkg::BR_NONE;
			idExJump     <= 1'b0;
			idExHalt     <= 1'b0;
		end else begin
			idExValid    <= 1'b1;
			idExRegWrite <= decRegWrite;
			idExMemRead  <= decMemRead;
			idExMemWrite <= decMemWrite;
			idExBranch   <= decBranch;
			idExJump     <= decJump;
			idExHalt     <= decHalt;
		end
	end

	always_ff @(posedge CLK) begin
		idExPc        <= ifIdPc;
		idExRs1       <= decRs1;
		idExRs2       <= decRs2;
		idExRd        <= decRd;
		idExImm       <= decImm;
		idExRd1       <= idRd1;
		idExRd2       <= idRd2;
		idExAluOp     <= decAluOp;
		idExAluSrcImm <= decAluSrcImm;
		idExJumpReg   <= decJumpReg;
		idExWbSel     <= decWbSel;
	end

	assign fwdBus.exRs1       = idExRs1;
	assign fwdBus.exRs2       = idExRs2;
	assign fwdBus.exRd        = idExRd;
	assign fwdBus.exIsLoad    = idExMemRead && idExRegWrite;
	assign fwdBus.memRd       = exMemRd;
	assign fwdBus.memRegWrite = exMemRegWrite;
	assign fwdBus.memIsLoad   = exMemMemRead;
	assign fwdBus.wbRd        = memWbRd;
	assign fwdBus.wbRegWrite  = memWbRegWrite;
	assign fwdBus.idRs1       = decRs1;
	assign fwdBus.idRs2       = decRs2;

	assign memFwdVal = (exMemWbSel == riscv_pipe_pkg::WB_LINK) ?
		riscv_isa_pkg::word_t'(exMemLink) : exMemAlu;
	assign exOpA  = pickOperand(fwdBus.fwdA, idExRd1, memFwdVal, RF_WD);
	assign exOpB  = pickOperand(fwdBus.fwdB, idExRd2, memFwdVal, RF_WD);
	assign exAluB = idExAluSrcImm ? idExImm : exOpB;

	riscv_alu uAlu (
		.a(exOpA),
		.b(exAluB),
		.op(idExAluOp),
		.result(exAluResult),
		.zero(exZero)
	);

	always_comb begin
		case (idExBranch)
			riscv_pipe_pkg::BR_EQ: exBrTaken = exZero;
			riscv_pipe_pkg::BR_NE: exBrTaken = !exZero;
			default:               exBrTaken = 1'b0;
		endcase
	end

	assign exBranchTarget = idExPc + idExImm[`PC_W-1:0];  // branches and JAL
	assign exTarget = (idExJump && idExJumpReg) ?
		{exAluResult[`PC_W-1:1], 1'b0} : exBranchTarget;
	assign exLink   = idExPc + riscv_pipe_pkg::pcAddr_t'(4);
	assign flush    = idExJump || exBrTaken;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			exMemValid    <= 1'b0;
			exMemRegWrite <= 1'b0;
			exMemMemRead  <= 1'b0;
			exMemMemWrite <= 1'b0;
			exMemHalt     <= 1'b0;
		end else begin
			exMemValid    <= idExValid;
			exMemRegWrite <= idExRegWrite;
			exMemMemRead  <= idExMemRead;
			exMemMemWrite <= idExMemWrite;
			exMemHalt     <= idExHalt;
		end
	end

	always_ff @(posedge CLK) begin
		exMemAlu       <= exAluResult;
		exMemStoreData <= exOpB;
		exMemLink      <= exLink;
		exMemRd        <= idExRd;
		exMemWbSel     <= idExWbSel;
	end

	assign D_MEM_ADDR = exMemAlu[13:2];  // word address
	assign D_MEM_DOUT = exMemStoreData;
	assign D_MEM_CSN  = !((exMemMemRead || exMemMemWrite) && !HALT);
	assign D_MEM_WEN  = !(exMemMemWrite && !HALT);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			memWbValid    <= 1'b0;
			memWbRegWrite <= 1'b0;
			memWbHalt     <= 1'b0;
		end else begin
			memWbValid    <= exMemValid;
			memWbRegWrite <= exMemRegWrite;
			memWbHalt     <= exMemHalt;
		end
	end

	always_ff @(posedge CLK) begin
		memWbAlu   <= exMemAlu;
		memWbLoad  <= D_MEM_DI;
		memWbLink  <= exMemLink;
		memWbRd    <= exMemRd;
		memWbWbSel <= exMemWbSel;
	end

	always_comb begin
		case (memWbWbSel)
			riscv_pipe_pkg::WB_MEM:  RF_WD = memWbLoad;
			riscv_pipe_pkg::WB_LINK: RF_WD = riscv_isa_pkg::word_t'(memWbLink);
			default:                 RF_WD = memWbAlu;
		endcase
	end

	assign RF_WA1 = memWbRd;
	assign RF_WE  = memWbRegWrite && !HALT;

	// retire count and sticky halt
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			NUM_INST <= '0;
			HALT     <= 1'b0;
		end else begin
			if (memWbValid && !HALT)
				NUM_INST <= NUM_INST + 1'b1;
			if (memWbValid && memWbHalt)
				HALT <= 1'b1;
		end
	end
endmodule

// ==== rtl/fwd_if.sv ====
`timescale 1ns/1ps

interface fwd_if;
	riscv_isa_pkg::regIdx_t exRs1, exRs2;   // sources of the instruction in EX
	riscv_isa_pkg::regIdx_t exRd;
	logic                   exIsLoad;       // EX holds a load that writes exRd
	riscv_isa_pkg::regIdx_t memRd;
	logic                   memRegWrite;
	logic                   memIsLoad;
	riscv_isa_pkg::regIdx_t wbRd;
	logic                   wbRegWrite;
	riscv_isa_pkg::regIdx_t idRs1, idRs2;   // sources of the instruction in ID

	riscv_pipe_pkg::fwdSel_e fwdA, fwdB;
	logic                    stall;

	modport unit (
		input  exRs1, exRs2, exRd, exIsLoad,
		input  memRd, memRegWrite, memIsLoad,
		input  wbRd, wbRegWrite, idRs1, idRs2,
		output fwdA, fwdB, stall
	);

	modport pipe (
		output exRs1, exRs2, exRd, exIsLoad,
		output memRd, memRegWrite, memIsLoad,
		output wbRd, wbRegWrite, idRs1, idRs2,
		input  fwdA, fwdB, stall
	);
endinterface

// ==== rtl/riscv_alu.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_alu (
	input  riscv_isa_pkg::word_t  a,
	input  riscv_isa_pkg::word_t  b,
	input  riscv_isa_pkg::aluOp_e op,
	output riscv_isa_pkg::word_t  result,
	output logic                  zero
);
	riscv_isa_pkg::word_t diff;
	logic                 lessThan;

	assign diff = a - b;

	// signed compare from the subtractor, sign bits decide when they differ
	assign lessThan = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : diff[`XLEN-1];

	always_comb begin
		case (op)
			riscv_isa_pkg::ALU_ADD: result = a + b;
			riscv_isa_pkg::ALU_SUB: result = diff;
			riscv_isa_pkg::ALU_AND: result = a & b;
			riscv_isa_pkg::ALU_OR:  result = a | b;
			riscv_isa_pkg::ALU_XOR: result = a ^ b;
			riscv_isa_pkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, lessThan};
			default:                result = a + b;
		endcase
	end

	assign zero = (result == '0);  // BEQ/BNE use this with SUB
endmodule

// ==== rtl/riscv_decoder.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module riscv_decoder (
	input  riscv_isa_pkg::word_t    instr,
	output riscv_isa_pkg::regIdx_t  rs1,
	output riscv_isa_pkg::regIdx_t  rs2,
	output riscv_isa_pkg::regIdx_t  rd,
	output riscv_isa_pkg::word_t    imm,
	output riscv_isa_pkg::aluOp_e   aluOp,
	output logic                    aluSrcImm,
	output logic                    regWrite,
	output logic                    memRead,
	output logic                    memWrite,
	output riscv_pipe_pkg::branch_e branch,
	output logic                    jump,
	output logic                    jumpReg,
	output riscv_pipe_pkg::wbSel_e  wbSel,
	output logic                    halt
);
	riscv_isa_pkg::opcode_e opcode;
	riscv_isa_pkg::aluOp_e  funcOp;
	riscv_isa_pkg::word_t   immI, immS, immB, immJ;
	logic [2:0]             funct3;
	logic [6:0]             funct7;
	logic                   isRegOp;
	logic                   funcOk;
	logic                   writesRd;

	assign opcode  = riscv_isa_pkg::opcode_e'(instr[6:0]);
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign isRegOp = (opcode == riscv_isa_pkg::OPC_OP);
	assign rs1     = instr[19:15];
	assign rs2     = instr[24:20];
	assign rd      = instr[11:7];

	assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
	assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{(`XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// x0 is never written, later stages rely on this
	assign regWrite = writesRd && (rd != '0);

	// funct3 to ALU op, shared by OP and OP_IMM
	always_comb begin
		funcOk = 1'b1;
		funcOp = riscv_isa_pkg::ALU_ADD;
		case (funct3)
			3'b000: if (isRegOp && funct7 == 7'b0100000) funcOp = riscv_isa_pkg::ALU_SUB;
			3'b010: funcOp = riscv_isa_pkg::ALU_SLT;
			3'b100: funcOp = riscv_isa_pkg::ALU_XOR;
			3'b110: funcOp = riscv_isa_pkg::ALU_OR;
			3'b111: funcOp = riscv_isa_pkg::ALU_AND;
			default: funcOk = 1'b0;  // shifts, SLTU
		endcase
		if (isRegOp && funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000))
			funcOk = 1'b0;
	end

	always_comb begin
		imm       = '0;
		aluOp     = riscv_isa_pkg::ALU_ADD;
		aluSrcImm = 1'b0;
		writesRd  = 1'b0;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		branch    = riscv_pipe_pkg::BR_NONE;
		jump      = 1'b0;
		jumpReg   = 1'b0;
		wbSel     = riscv_pipe_pkg::WB_ALU;
		halt      = 1'b0;
		case (opcode)
			riscv_isa_pkg::OPC_OP: begin
				writesRd = funcOk;
				aluOp    = funcOp;
			end
			riscv_isa_pkg::OPC_OP_IMM: begin
				writesRd  = funcOk;
				aluOp     = funcOp;
				aluSrcImm = 1'b1;
				imm       = immI;
			end
			riscv_isa_pkg::OPC_LOAD: if (funct3 == 3'b010) begin  // LW only
				writesRd  = 1'b1;
				memRead   = 1'b1;
				aluSrcImm = 1'b1;
				imm       = immI;
				wbSel     = riscv_pipe_pkg::WB_MEM;
			end
			riscv_isa_pkg::OPC_STORE: if (funct3 == 3'b010) begin  // SW only
				memWrite  = 1'b1;
				aluSrcImm = 1'b1;
				imm       = immS;
			end
			riscv_isa_pkg::OPC_BRANCH: begin
				aluOp = riscv_isa_pkg::ALU_SUB;
				imm   = immB;
				if (funct3 == 3'b000)
					branch = riscv_pipe_pkg::BR_EQ;
				else if (funct3 == 3'b001)
					branch = riscv_pipe_pkg::BR_NE;
			end
			riscv_isa_pkg::OPC_JAL: begin
				writesRd = 1'b1;
				jump     = 1'b1;
				imm      = immJ;
				wbSel    = riscv_pipe_pkg::WB_LINK;
			end
			riscv_isa_pkg::OPC_JALR: if (funct3 == 3'b000) begin
				writesRd  = 1'b1;
				jump      = 1'b1;
				jumpReg   = 1'b1;
				aluSrcImm = 1'b1;  // target is rs1 + imm through the ALU
				imm       = immI;
				wbSel     = riscv_pipe_pkg::WB_LINK;
			end
			riscv_isa_pkg::OPC_SYSTEM: halt = (instr == `HALT_INSTR);
			default: ;  // bubble
		endcase
	end
endmodule

// ==== rtl/riscv_forward_unit.sv ====
`timescale 1ns/1ps

module riscv_forward_unit (
	fwd_if.unit fwd
);
	logic memHitA, memHitB;
	logic wbHitA, wbHitB;
	logic loadHitA, loadHitB;

	// newest producer wins, MEM before WB
	function automatic riscv_pipe_pkg::fwdSel_e pickSource(
		input logic memHit,
		input logic wbHit
	);
		if (memHit)
			return riscv_pipe_pkg::FWD_MEM;
		else if (wbHit)
			return riscv_pipe_pkg::FWD_WB;
		return riscv_pipe_pkg::FWD_REG;
	endfunction

	// a load in MEM has no data yet, the stall keeps consumers away from it
	assign memHitA = fwd.memRegWrite && !fwd.memIsLoad && (fwd.memRd == fwd.exRs1);
	assign memHitB = fwd.memRegWrite && !fwd.memIsLoad && (fwd.memRd == fwd.exRs2);
	assign wbHitA  = fwd.wbRegWrite && (fwd.wbRd == fwd.exRs1);
	assign wbHitB  = fwd.wbRegWrite && (fwd.wbRd == fwd.exRs2);

	assign fwd.fwdA = pickSource(memHitA, wbHitA);
	assign fwd.fwdB = pickSource(memHitB, wbHitB);

	// load-use: the consumer waits one cycle in ID
	assign loadHitA  = fwd.exRd == fwd.idRs1;
	assign loadHitB  = fwd.exRd == fwd.idRs2;
	assign fwd.stall = fwd.exIsLoad && (loadHitA || loadHitB);
endmodule

// ==== rtl/riscv_isa_pkg.sv ====
`include "riscv_macros.svh"

package riscv_isa_pkg;

	typedef logic [`XLEN-1:0]      word_t;    // data or instruction word
	typedef logic [`REG_IDX_W-1:0] regIdx_t;  // x0..x31

	// major opcodes in instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,  // also the compare for BEQ and BNE
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5   // signed
	} aluOp_e;

endpackage

// ==== rtl/riscv_pipe_pkg.sv ====
`include "riscv_macros.svh"

package riscv_pipe_pkg;

	typedef logic [`PC_W-1:0] pcAddr_t;  // byte address

	// where an EX operand comes from
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,  // value read in ID
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwdSel_e;

	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_LINK = 2'd2   // PC+4 of a jump
	} wbSel_e;

	typedef enum logic [1:0] {
		BR_NONE = 2'd0,
		BR_EQ   = 2'd1,
		BR_NE   = 2'd2
	} branch_e;

endpackage

// ==== tb/RISCV_TOP_tb.sv ====
`timescale 1ns/1ps
`include "riscv_macros.svh"

module RISCV_TOP_tb;
	localparam logic [6:0] opReg    = riscv_isa_pkg::OPC_OP;
	localparam logic [6:0] opImm    = riscv_isa_pkg::OPC_OP_IMM;
	localparam logic [6:0] opLoad   = riscv_isa_pkg::OPC_LOAD;
	localparam logic [6:0] opStore  = riscv_isa_pkg::OPC_STORE;
	localparam logic [6:0] opBranch = riscv_isa_pkg::OPC_BRANCH;
	localparam logic [6:0] opJal    = riscv_isa_pkg::OPC_JAL;
	localparam logic [6:0] opJalr   = riscv_isa_pkg::OPC_JALR;

	logic                    CLK;
	logic                    RSTn;
	logic                    I_MEM_CSN, D_MEM_CSN, D_MEM_WEN, RF_WE, HALT;
	riscv_pipe_pkg::pcAddr_t I_MEM_ADDR;
	riscv_isa_pkg::word_t    I_MEM_DI, D_MEM_DI, D_MEM_DOUT, RF_RD1, RF_RD2, RF_WD, NUM_INST;
	logic [11:0]             D_MEM_ADDR;
	riscv_isa_pkg::regIdx_t  RF_RA1, RF_RA2, RF_WA1;

	riscv_isa_pkg::word_t imem [1024];
	riscv_isa_pkg::word_t dmem [4096];
	riscv_isa_pkg::word_t modelMem [4096];  // reference copy of the data memory
	riscv_isa_pkg::word_t rf [32];

	// expected writes from the reference model, in program order
	riscv_isa_pkg::regIdx_t expRegAddr [64];
	riscv_isa_pkg::word_t   expRegData [64];
	logic [11:0]            expStAddr [16];
	riscv_isa_pkg::word_t   expStData [16];
	int regCount = 0;
	int stCount  = 0;
	int expCount = 0;
	int regPos   = 0;  // next register write to match
	int stPos    = 0;

	riscv_isa_pkg::regIdx_t expWa;
	riscv_isa_pkg::word_t   expWd, expSd;
	logic [11:0]            expSa;
	logic [15:0]            lfsr = 16'd98;
	logic                   resetDly = 1'b0;
	logic                   haltSeen = 1'b0;

	RISCV_TOP u_RISCV_TOP (
		.CLK(CLK),
		.RSTn(RSTn),
		.I_MEM_CSN(I_MEM_CSN),
		.I_MEM_DI(I_MEM_DI),
		.I_MEM_ADDR(I_MEM_ADDR),
		.D_MEM_CSN(D_MEM_CSN),
		.D_MEM_DI(D_MEM_DI),
		.D_MEM_DOUT(D_MEM_DOUT),
		.D_MEM_ADDR(D_MEM_ADDR),
		.D_MEM_WEN(D_MEM_WEN),
		.RF_WE(RF_WE),
		.RF_RA1(RF_RA1),
		.RF_RA2(RF_RA2),
		.RF_WA1(RF_WA1),
		.RF_RD1(RF_RD1),
		.RF_RD2(RF_RD2),
		.RF_WD(RF_WD),
		.HALT(HALT),
		.NUM_INST(NUM_INST)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// memories and register file read in the same cycle
	assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
	assign D_MEM_DI = dmem[D_MEM_ADDR];
	assign RF_RD1   = (RF_RA1 == '0) ? '0 : rf[RF_RA1];
	assign RF_RD2   = (RF_RA2 == '0) ? '0 : rf[RF_RA2];

	always @(posedge CLK) begin
		if (!D_MEM_CSN && !D_MEM_WEN)
			dmem[D_MEM_ADDR] <= D_MEM_DOUT;
		if (RF_WE)
			rf[RF_WA1] <= RF_WD;
	end

	always @(posedge CLK) begin
		resetDly <= RSTn;
		if (HALT === 1'b1)
			haltSeen <= 1'b1;
		if (RF_WE === 1'b1)
			regPos <= regPos + 1;
		if (D_MEM_WEN === 1'b0)
			stPos <= stPos + 1;
	end

	assign expWa = expRegAddr[regPos];
	assign expWd = expRegData[regPos];
	assign expSa = expStAddr[stPos];
	assign expSd = expStData[stPos];

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic reportMismatch(input string msg);
		stopRun($sformatf("Error at %0t ns: %s", $time, msg));
	endtask

	// covers the reset cycles and the first cycle after reset
	assert property (@(posedge CLK) resetDly |->
		I_MEM_CSN && D_MEM_CSN && D_MEM_WEN && !RF_WE && !HALT && NUM_INST == '0)
		else reportMismatch("outputs are not at their reset values");

	assert property (@(posedge CLK) RF_WE |-> RF_WA1 != '0)
		else reportMismatch("register write to x0");

	assert property (@(posedge CLK) RF_WE |-> regPos < regCount)
		else reportMismatch("register write beyond the expected ones");

	assert property (@(posedge CLK) RF_WE |-> RF_WA1 == expWa && RF_WD == expWd)
		else reportMismatch($sformatf("register write x%0d=%h, expected x%0d=%h",
			$sampled(RF_WA1), $sampled(RF_WD), $sampled(expWa), $sampled(expWd)));

	assert property (@(posedge CLK) !D_MEM_WEN |-> !D_MEM_CSN && stPos < stCount)
		else reportMismatch("unexpected store");

	assert property (@(posedge CLK) !D_MEM_WEN |-> D_MEM_ADDR == expSa && D_MEM_DOUT == expSd)
		else reportMismatch($sformatf("store [%h]=%h, expected [%h]=%h",
			$sampled(D_MEM_ADDR), $sampled(D_MEM_DOUT), $sampled(expSa), $sampled(expSd)));

	// fetch and data memory idle, PC frozen
	assert property (@(posedge CLK) haltSeen |-> HALT && !RF_WE && D_MEM_WEN && D_MEM_CSN &&
		I_MEM_CSN && $stable(I_MEM_ADDR))
		else reportMismatch("activity after halt or HALT dropped");

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
	endfunction

	task automatic takeBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] rType(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opReg};
	endfunction

	function automatic logic [31:0] iType(logic [6:0] opc, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic logic [31:0] sType(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(int f3, int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] jType(int rd, int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
	endfunction

	task automatic loadProgram();
		logic [31:0] v;
		int rnd [6];
		for (int i = 0; i < 1024; i++)
			imem[i] = iType(opImm, 0, 31, 0, i);  // ADDI x31, x0, i
		for (int i = 0; i < 4096; i++)
			dmem[i] = {i[11:0], 8'h5a, ~i[11:0]};
		for (int i = 64; i < 72; i++) begin
			takeBits(32, v);
			dmem[i] = v;
		end
		for (int i = 0; i < 32; i++)
			rf[i] = '0;
		for (int i = 0; i < 6; i++) begin
			takeBits(12, v);
			rnd[i] = int'(v[11:0]);
		end
		imem[0]  = iType(opImm, 0, 1, 0, rnd[0]);
		imem[1]  = iType(opImm, 0, 2, 0, rnd[1]);
		imem[2]  = rType(0, 0, 3, 1, 2);          // x2 from MEM, x1 from WB
		imem[3]  = rType(32, 0, 4, 3, 1);         // SUB
		imem[4]  = rType(0, 4, 5, 4, 3);          // XOR
		imem[5]  = rType(0, 7, 6, 5, 2);          // AND
		imem[6]  = rType(0, 6, 7, 6, 4);          // OR
		imem[7]  = rType(0, 2, 8, 4, 3);          // SLT
		imem[8]  = iType(opImm, 2, 9, 5, rnd[2]);
		imem[9]  = iType(opImm, 4, 10, 7, rnd[3]);
		imem[10] = iType(opImm, 7, 11, 10, rnd[4]);
		imem[11] = iType(opImm, 6, 12, 11, rnd[5]);
		imem[12] = iType(opImm, 0, 20, 0, 256);   // data base, word 64
		imem[13] = sType(3, 20, 0);
		imem[14] = iType(opLoad, 2, 13, 20, 0);   // load right behind the store
		imem[15] = rType(0, 0, 14, 13, 1);        // load-use
		imem[16] = iType(opLoad, 2, 15, 20, 4);
		imem[17] = sType(15, 20, 8);              // loaded value as store data
		imem[18] = iType(opLoad, 2, 16, 20, 12);
		imem[19] = rType(32, 0, 17, 16, 15);
		imem[20] = bType(0, 3, 3, 12);            // BEQ taken
		imem[21] = iType(opImm, 0, 31, 0, 1);
		imem[22] = sType(31, 20, 0);
		imem[23] = bType(1, 3, 3, 8);             // BNE not taken
		imem[24] = iType(opImm, 6, 18, 0, 1);
		imem[25] = bType(1, 18, 0, 12);           // BNE taken, x18 from MEM
		imem[26] = iType(opImm, 0, 31, 0, 2);
		imem[27] = sType(18, 20, 0);
		imem[28] = bType(0, 18, 0, 8);            // BEQ not taken
		imem[29] = jType(19, 12);
		imem[30] = iType(opImm, 0, 31, 0, 3);
		imem[31] = sType(0, 20, 4);
		imem[32] = iType(opImm, 0, 21, 0, 172);
		imem[33] = iType(opJalr, 0, 22, 21, 5);   // 177 with bit 0 cleared is word 44
		imem[34] = iType(opImm, 0, 31, 0, 4);
		imem[35] = sType(21, 20, 0);
		imem[44] = sType(22, 20, 16);
		imem[45] = rType(0, 0, 23, 19, 22);
		imem[46] = iType(opImm, 0, 0, 1, rnd[0]);  // targets x0, retires without a write
		imem[47] = `HALT_INSTR;
	endtask

	function automatic logic [31:0] computeOp(logic [2:0] f3, logic sub, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	// instruction-level model of the program, one instruction per pass
	task automatic runModel(output logic ok);
		riscv_isa_pkg::word_t regs [32];
		logic [31:0] ins, a, b, res, ea, pc, nextPc, immI, immS, immB, immJ;
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic        wr, stop;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 4096; i++)
			modelMem[i] = dmem[i];
		pc   = '0;
		stop = 1'b0;
		while (!stop && expCount < 1000) begin
			ins    = imem[pc[11:2]];
			opc    = ins[6:0];
			rd     = ins[11:7];
			f3     = ins[14:12];
			a      = regs[ins[19:15]];
			b      = regs[ins[24:20]];
			immI   = {{20{ins[31]}}, ins[31:20]};
			immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			ea     = a + immI;
			nextPc = pc + 4;
			wr     = 1'b1;
			res    = '0;
			case (opc)
				opReg:  res = computeOp(f3, ins[30], a, b);
				opImm:  res = computeOp(f3, 1'b0, a, immI);
				opLoad: res = modelMem[ea[13:2]];
				opStore: begin
					wr = 1'b0;
					ea = a + immS;
					modelMem[ea[13:2]]  = b;
					expStAddr[stCount] = ea[13:2];
					expStData[stCount] = b;
					stCount++;
				end
				opBranch: begin
					wr = 1'b0;
					if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
						nextPc = pc + immB;
				end
				opJal: begin
					res    = pc + 4;
					nextPc = pc + immJ;
				end
				opJalr: begin
					res    = pc + 4;
					nextPc = ea & ~32'd1;
				end
				default: begin
					wr   = 1'b0;
					stop = (ins == `HALT_INSTR);
				end
			endcase
			if (wr && rd != '0) begin
				regs[rd] = res;
				expRegAddr[regCount] = rd;
				expRegData[regCount] = res;
				regCount++;
			end
			pc = nextPc;
			expCount++;  // EBREAK counts too
		end
		ok = stop;
	endtask

	initial begin
		int   cycles;
		logic modelOk;
		RSTn = 1'b1;
		loadProgram();
		runModel(modelOk);
		if (!modelOk)
			stopRun("reference model never reached EBREAK");
		else begin
			repeat (8) @(posedge CLK);
			#2 RSTn = 1'b0;
			cycles = 0;
			while (!HALT && cycles < 3000) begin
				@(posedge CLK);
				#2;
				cycles++;
			end
			if (!HALT)
				stopRun("timeout, HALT did not rise within 3000 cycles");
			else begin
				repeat (10) begin
					@(posedge CLK);
					#2;
				end
				assert (NUM_INST == expCount)
					else reportMismatch($sformatf("NUM_INST %0d, expected %0d", NUM_INST, expCount));
				assert (regPos == regCount)
					else reportMismatch($sformatf("%0d of %0d register writes seen", regPos, regCount));
				assert (stPos == stCount)
					else reportMismatch($sformatf("%0d of %0d stores seen", stPos, stCount));
				$display("Done: no errors");
				$finish;
			end
		end
	end
endmodule
